// ==== hw/game_pkg.sv ====
package game_pkg;

    // horizontal position in pixels
    typedef logic [11:0] xpos_t;

    // host register data word
    typedef logic [15:0] wb_data_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LEFT  = 2'd1,
        RIGHT = 2'd2
    } move_state_t;

    // playfield limits
    localparam xpos_t SCREEN_RIGHT = 12'd873;
    localparam xpos_t BLOCK_LEFT   = 12'd425;  // left edge of the block
    localparam xpos_t BLOCK_RIGHT  = 12'd604;  // right edge of the block

    // stable samples before a button change is accepted
    localparam int DEBOUNCE_CYCLES = 4;

    // wishbone word addresses
    localparam logic [1:0] REG_P0   = 2'd0;
    localparam logic [1:0] REG_P1   = 2'd1;
    localparam logic [1:0] REG_CTRL = 2'd2;

endpackage

// ==== hw/player_if.sv ====
`timescale 1ns/1ps

interface player_if;
    import game_pkg::*;

    logic        left;   // debounced left button
    logic        right;  // debounced right button
    xpos_t       xpos;
    move_state_t state;

    modport sync (
        output left,
        output right
    );

    modport ctl (
        input  left,
        input  right,
        output xpos,
        output state
    );

    // host side only looks at the results
    modport host (
        input xpos,
        input state
    );

endinterface

// ==== hw/input_sync.sv ====
`timescale 1ns/1ps

module input_sync (
    input  logic   clk,
    input  logic   rst,
    input  logic   raw_left,
    input  logic   raw_right,
    input  logic   raw_gate,
    output logic   gate,
    player_if.sync p
);
    import game_pkg::*;

    localparam int NUM_IN = 3;  // left, right, gate
    localparam int CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

    logic [NUM_IN-1:0] raw;
    logic [NUM_IN-1:0] s1;      // first synchronizer stage
    logic [NUM_IN-1:0] s2;      // second synchronizer stage
    logic [NUM_IN-1:0] stable;  // debounced value
    logic [CNT_W-1:0]  cnt [NUM_IN];

    assign raw = {raw_gate, raw_right, raw_left};

    always_ff @(posedge clk) begin
        if (rst) begin
            s1 <= '0;
            s2 <= '0;
        end else begin
            s1 <= raw;
            s2 <= s1;
        end
    end

    // each input counts how long it has disagreed with its accepted value
    always_ff @(posedge clk) begin
        if (rst) begin
            stable <= '0;
            for (int i = 0; i < NUM_IN; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_IN; i++) begin
                if (s2[i] == stable[i]) begin
                    cnt[i] <= '0;                      // glitch or no change
                end else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    cnt[i]    <= '0;
                    stable[i] <= s2[i];                // held long enough
                end else begin
                    cnt[i] <= cnt[i] + CNT_W'(1);
                end
            end
        end
    end

    assign p.left  = stable[0];
    assign p.right = stable[1];
    assign gate    = stable[2];

endmodule

// ==== hw/frame_tick_gen.sv ====
`timescale 1ns/1ps

module frame_tick_gen #(
    parameter int FRAME_CYCLES = 420000  // 800 x 525 clocks per video frame
) (
    input  logic clk,
    input  logic rst,
    output logic frame
);

    localparam int CNT_W = $clog2(FRAME_CYCLES);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            frame <= 1'b0;
        end else if (cnt == CNT_W'(FRAME_CYCLES - 1)) begin
            cnt   <= '0;
            frame <= 1'b1;  // one pulse per wrap
        end else begin
            cnt   <= cnt + CNT_W'(1);
            frame <= 1'b0;
        end
    end

    // the frame pulse must never stretch into a second cycle
    a_frame_single: assert property (
        @(posedge clk) disable iff (rst) frame |=> !frame
    ) else $error("frame pulse longer than one cycle");

endmodule

// ==== hw/player_ctl.sv ====
`timescale 1ns/1ps

module player_ctl (
    input  logic  clk,
    input  logic  rst,
    input  logic  frame,
    input  logic  gate,
    input  logic  restart,
    player_if.ctl p
);
    import game_pkg::*;

    move_state_t state_nxt;
    xpos_t       xpos_nxt;
    xpos_t       pos_inc;   // candidate position one step right
    xpos_t       pos_dec;   // candidate position one step left
    logic        right_ok;
    logic        left_ok;

    // strictly inside the block, the edges themselves are free
    function automatic logic in_block(xpos_t x);
        return (x > BLOCK_LEFT) && (x < BLOCK_RIGHT);
    endfunction

    assign pos_inc = p.xpos + xpos_t'(1);
    assign pos_dec = p.xpos - xpos_t'(1);

    // a step touching the block interior needs the gate held
    assign right_ok = (p.xpos != SCREEN_RIGHT) &&
                      (gate || !(in_block(p.xpos) || in_block(pos_inc)));
    assign left_ok  = (p.xpos != '0) &&
                      (gate || !(in_block(p.xpos) || in_block(pos_dec)));

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            p.state <= IDLE;
            p.xpos  <= '0;
        end else if (frame) begin
            p.state <= state_nxt;
            p.xpos  <= xpos_nxt;
        end
    end

    always_comb begin
        state_nxt = p.state;
        xpos_nxt  = p.xpos;

        case (p.state)
            IDLE: begin
                // right takes priority when both are held
                if (p.right) begin
                    state_nxt = RIGHT;
                end else if (p.left) begin
                    state_nxt = LEFT;
                end else begin
                    state_nxt = IDLE;
                end
            end

            RIGHT: begin
                if (p.right) begin
                    state_nxt = RIGHT;
                    if (right_ok) begin
                        xpos_nxt = pos_inc;
                    end
                end else begin
                    state_nxt = IDLE;  // released
                end
            end

            LEFT: begin
                if (p.left) begin
                    state_nxt = LEFT;
                    if (left_ok) begin
                        xpos_nxt = pos_dec;
                    end
                end else begin
                    state_nxt = IDLE;
                end
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // movement never carries a player past the right screen edge
    a_xpos_range: assert property (
        @(posedge clk) disable iff (rst) p.xpos <= SCREEN_RIGHT
    ) else $error("xpos beyond right screen edge: %h", p.xpos);

endmodule

// ==== hw/wb_game_regs.sv ====
`timescale 1ns/1ps

module wb_game_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [1:0]         wb_adr,
    input  game_pkg::wb_data_t wb_dat_w,
    input  logic               frame,
    output game_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack,
    output logic               restart,
    player_if.host             p0,
    player_if.host             p1
);
    import game_pkg::*;

    logic     req;
    logic     served;     // ack already given for the current strobe
    logic     take;       // accept the access on this edge
    wb_data_t frame_cnt;
    wb_data_t rd_mux;

    assign req  = wb_cyc && wb_stb;
    assign take = req && !wb_ack && !served;

    always_comb begin
        case (wb_adr)
            REG_P0:   rd_mux = {2'b00, p0.state, p0.xpos};
            REG_P1:   rd_mux = {2'b00, p1.state, p1.xpos};
            REG_CTRL: rd_mux = frame_cnt;
            default:  rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            served    <= 1'b0;
            restart   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            wb_ack  <= take;
            served  <= req && (served || wb_ack);  // cleared once stb drops
            restart <= take && wb_we && (wb_adr == REG_CTRL) && wb_dat_w[0];
            if (frame) begin
                frame_cnt <= frame_cnt + wb_data_t'(1);
            end
        end
    end

    // read data is captured together with the ack
    always_ff @(posedge clk) begin
        if (take) begin
            wb_dat_r <= rd_mux;
        end
    end

    // master holds its request until ack, so ack always lands inside it
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_ack outside of an active cycle");

endmodule

// ==== hw/game_top.sv ====
`timescale 1ns/1ps

module game_top #(
    parameter int FRAME_CYCLES = 420000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               left0,
    input  logic               right0,
    input  logic               left1,
    input  logic               right1,
    input  logic               gate_btn,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [1:0]         wb_adr,
    input  game_pkg::wb_data_t wb_dat_w,
    output game_pkg::wb_data_t wb_dat_r,
    output logic               wb_ack,
    output logic               frame
);

    logic gate;     // debounced gate button, shared by both players
    logic restart;

    player_if p0_if ();
    player_if p1_if ();

    input_sync u_sync0 (
        .clk       (clk),
        .rst       (rst),
        .raw_left  (left0),
        .raw_right (right0),
        .raw_gate  (gate_btn),
        .gate      (gate),
        .p         (p0_if.sync)
    );

    // second player has no gate button of its own
    input_sync u_sync1 (
        .clk       (clk),
        .rst       (rst),
        .raw_left  (left1),
        .raw_right (right1),
        .raw_gate  (1'b0),
        .gate      (),
        .p         (p1_if.sync)
    );

    frame_tick_gen #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_tick (
        .clk   (clk),
        .rst   (rst),
        .frame (frame)
    );

    player_ctl u_ctl0 (.clk(clk), .rst(rst), .frame(frame), .gate(gate),
                       .restart(restart), .p(p0_if.ctl));

    player_ctl u_ctl1 (.clk(clk), .rst(rst), .frame(frame), .gate(gate),
                       .restart(restart), .p(p1_if.ctl));

    wb_game_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .frame    (frame),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .restart  (restart),
        .p0       (p0_if.host),
        .p1       (p1_if.host)
    );

endmodule

// ==== sim/game_tb.sv ====
`timescale 1ns/1ps

module game_tb;
    import game_pkg::*;

    localparam int FRAME_CYCLES  = 64;
    localparam int FRAME_TIMEOUT = 4 * FRAME_CYCLES;  // cycles to wait for a frame pulse
    localparam int ACK_TIMEOUT   = 16;

    logic       clk;
    logic       rst;
    logic       left0;
    logic       right0;
    logic       left1;
    logic       right1;
    logic       gate_btn;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [1:0] wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;
    logic       frame;

    int          model_x [2];   // expected positions
    int          model_st [2];  // expected states
    int          got_x [2];     // last values read back
    int          got_st [2];
    int          err_cnt;
    int          test_cnt;
    int          fail_cnt;
    int          test_err_start;
    string       test_name;
    logic [31:0] seed;
    int          since_frame;   // clocks since the last frame pulse
    bit          seen_frame;

    game_top #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .left0    (left0),
        .right0   (right0),
        .left1    (left1),
        .right1   (right1),
        .gate_btn (gate_btn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .frame    (frame)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // frame pulses come exactly FRAME_CYCLES clocks apart
    always @(negedge clk) begin
        if (rst) begin
            since_frame = 0;
            seen_frame  = 1'b0;
        end else begin
            since_frame++;
            if (frame) begin
                if (seen_frame) begin
                    check_value("frame period", since_frame, FRAME_CYCLES);
                end
                seen_frame  = 1'b1;
                since_frame = 0;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // only the block interior is guarded
    function automatic bit inside_block(input int x);
        return (x > int'(BLOCK_LEFT)) && (x < int'(BLOCK_RIGHT));
    endfunction

    // expected {state, xpos} of one player after a frame edge
    function automatic int ref_next(input int st, input int x, input bit l, input bit r,
                                    input bit g);
        int ns;
        int nx;
        bit blocked;
        ns = st;
        nx = x;
        if (st == int'(RIGHT) && r) begin
            blocked = !g && (inside_block(x) || inside_block(x + 1));
            if (x < int'(SCREEN_RIGHT) && !blocked) begin
                nx = x + 1;
            end
        end else if (st == int'(LEFT) && l) begin
            blocked = !g && (inside_block(x) || inside_block(x - 1));
            if (x > 0 && !blocked) begin
                nx = x - 1;
            end
        end else if (st == int'(IDLE)) begin
            if (r) begin
                ns = int'(RIGHT);  // right wins over left
            end else if (l) begin
                ns = int'(LEFT);
            end
        end else begin
            ns = int'(IDLE);  // held direction released
        end
        return (ns << 12) | nx;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    // one classic cycle that ends at a falling edge with the bus idle
    task automatic wb_access(input bit we, input logic [1:0] adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            abort_run("timeout: the register block never acknowledged the access");
        end
        rdata = wb_dat_r;
        @(negedge clk);  // bus released after the ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);  // slave needs stb low for a cycle before the next ack
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        @(negedge clk);
        while (!frame && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!frame) begin
            abort_run("timeout: no frame pulse seen");
        end
    endtask

    task automatic check_players();
        wb_data_t d0;
        wb_data_t d1;
        wb_access(1'b0, REG_P0, '0, d0);
        wb_access(1'b0, REG_P1, '0, d1);
        got_x[0]  = int'(d0[11:0]);
        got_st[0] = int'(d0[13:12]);
        got_x[1]  = int'(d1[11:0]);
        got_st[1] = int'(d1[13:12]);
        check_value("p0 xpos", got_x[0], model_x[0]);
        check_value("p0 state", got_st[0], model_st[0]);
        check_value("p1 xpos", got_x[1], model_x[1]);
        check_value("p1 state", got_st[1], model_st[1]);
    endtask

    // inputs held for the coming frame and compared with the model after it
    task automatic run_frame(input bit l0, input bit r0, input bit l1, input bit r1,
                             input bit g);
        int nxt;
        left0    = l0;
        right0   = r0;
        left1    = l1;
        right1   = r1;
        gate_btn = g;
        wait_frame();
        @(negedge clk);  // the frame edge has passed
        nxt = ref_next(model_st[0], model_x[0], l0, r0, g);
        model_st[0] = nxt >> 12;
        model_x[0]  = nxt & 32'hfff;
        nxt = ref_next(model_st[1], model_x[1], l1, r1, g);
        model_st[1] = nxt >> 12;
        model_x[1]  = nxt & 32'hfff;
        check_players();
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt == test_err_start) begin
            $display("test %0d %s: passed", test_cnt, test_name);
        end else begin
            $display("test %0d %s: failed", test_cnt, test_name);
            fail_cnt++;
        end
    endtask

    initial begin
        wb_data_t cnt_a;
        wb_data_t cnt_b;
        wb_data_t unused_rd;
        int frames;
        int hold;

        rst      = 1'b1;
        left0    = 1'b0;
        right0   = 1'b0;
        left1    = 1'b0;
        right1   = 1'b0;
        gate_btn = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        err_cnt  = 0;
        test_cnt = 0;
        fail_cnt = 0;
        seed     = 32'h0a21_7765;
        for (int i = 0; i < 2; i++) begin
            model_x[i]  = 0;
            model_st[i] = int'(IDLE);
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_frame();
        @(negedge clk);

        start_test("reset state and frame counter");
        check_players();
        wb_access(1'b0, REG_CTRL, '0, cnt_a);
        check_value("frame_cnt", int'(cnt_a), 1);  // one frame since reset
        repeat (3) run_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        wb_access(1'b0, REG_CTRL, '0, cnt_b);
        check_value("frame_cnt", int'(cnt_b), 4);
        end_test();

        start_test("block stops player 0");
        repeat (int'(BLOCK_LEFT) + 6) run_frame(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        check_value("p0 xpos", got_x[0], int'(BLOCK_LEFT));
        check_value("p0 state", got_st[0], int'(RIGHT));
        run_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        check_value("p0 state", got_st[0], int'(IDLE));
        end_test();

        start_test("gate opens the block");
        repeat (190) run_frame(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        assert (got_x[0] > int'(BLOCK_RIGHT)) else begin
            $display("player 0 did not get past the block with the gate held");
            err_cnt++;
        end
        repeat (20) run_frame(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        check_value("p0 xpos", got_x[0], int'(BLOCK_RIGHT));
        check_value("p0 state", got_st[0], int'(LEFT));
        end_test();

        start_test("player 1 edge and priority");
        repeat (4) run_frame(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        check_value("p1 xpos", got_x[1], 0);
        check_value("p1 state", got_st[1], int'(LEFT));
        run_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (3) run_frame(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        check_value("p1 state", got_st[1], int'(RIGHT));
        check_value("p1 xpos", got_x[1], 2);
        end_test();

        start_test("random inputs");
        frames = 0;
        while (frames < 200) begin
            seed = lcg_next(seed);
            hold = int'(seed[26:25]) + 1;  // keep a pattern for 1 to 4 frames
            for (int k = 0; k < hold && frames < 200; k++) begin
                run_frame(seed[20], seed[21], seed[22], seed[23], seed[24]);
                frames++;
            end
        end
        end_test();

        start_test("restart");
        repeat (3) run_frame(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        wb_access(1'b1, REG_CTRL, 16'h0001, unused_rd);
        for (int i = 0; i < 2; i++) begin
            model_x[i]  = 0;
            model_st[i] = int'(IDLE);
        end
        check_players();
        run_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end_test();

        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/game_pkg.sv
hw/player_if.sv
hw/input_sync.sv
hw/frame_tick_gen.sv
hw/player_ctl.sv
hw/wb_game_regs.sv
hw/game_top.sv
sim/game_tb.sv

// ==== Makefile ====
# Verilator build and run for the game movement testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = game_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crashed simulation also counts as a failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
